/* verilog/vst_defines.svh */
// ====================
// Vector store engine sizing macros
// Lane count, register file depth and bus widths
// ====================
`ifndef VST_DEFINES_SVH
`define VST_DEFINES_SVH

// Register file geometry
`define VST_LANES      8    // 32-bit lanes per vector register
`define VST_NUM_VREGS  32   // Architectural vector registers

// Datapath widths
`define VST_DATA_W     32   // One element
`define VST_ADDR_W     32   // Memory address

// Vector length must reach LANES * NUM_VREGS so it needs the extra bit
`define VST_VL_W       ($clog2(`VST_LANES * `VST_NUM_VREGS) + 1)

`endif

/* verilog/vst_pkg.sv */
// ====================
// Vector store engine types
// ====================
`include "vst_defines.svh"

package vst_pkg;

    // Addressing mode of a store
    typedef enum logic [1:0] {
        OP_UNIT_STRIDED = 2'd0,  // Consecutive elements 4 bytes apart
        OP_STRIDED      = 2'd1,  // Fixed byte stride
        OP_INDEXED      = 2'd2   // Per-element offset from a second register
    } mem_op_e;

    // Register number and lane pointer
    typedef logic [$clog2(`VST_NUM_VREGS)-1:0] vreg_idx_t;
    typedef logic [$clog2(`VST_LANES):0]       lane_idx_t;  // Can point one past the last lane

    // Lengths, addresses and payloads
    typedef logic [`VST_VL_W-1:0]               vl_t;
    typedef logic [`VST_ADDR_W-1:0]             addr_t;
    typedef logic [`VST_DATA_W-1:0]             elem_t;
    typedef logic [`VST_LANES*`VST_DATA_W-1:0]  vreg_data_t;   // Lane 0 in the low bits

endpackage

/* verilog/vst_sequencer.sv */
// ====================
// Store sequencer
// Walks the elements register by register and drives the handshakes
// ====================
`include "vst_defines.svh"

module vst_sequencer import vst_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid_i,        // Instruction offered
    input  vl_t       vl_i,
    input  vreg_idx_t data_reg_i,
    input  vreg_idx_t index_reg_i,
    input  logic      grant_i,        // Memory took the request
    output logic      ready_o,
    output logic      busy_o,
    output logic      accept_o,
    output logic      advance_o,
    output lane_idx_t elem_ptr_o,
    output vreg_idx_t data_reg_o,
    output vreg_idx_t index_reg_o,
    output logic      req_en_o,
    output logic      unlock_en_o,
    output vreg_idx_t unlock_reg_o
);

    localparam int LANE_BITS = $clog2(`VST_LANES);

    // Lane mask for the first n elements of a register
    function automatic logic [`VST_LANES-1:0] lane_mask(input vl_t n);
        logic [`VST_LANES-1:0] m;
        if (n >= vl_t'(`VST_LANES)) begin
            m = '1;                                  // Whole register
        end else begin
            m = ~({`VST_LANES{1'b1}} << n);          // Partial tail
        end
        return m;
    endfunction

    // ====================
    // State
    // ====================
    logic [`VST_LANES-1:0] pending;      // Lanes still to be sent in this register
    logic [`VST_LANES+1:0] pending_ext;  // Zero padded so ptr and ptr+1 stay in range
    lane_idx_t             ptr;          // Current lane
    lane_idx_t             ptr_nxt;
    vreg_idx_t             loop_cnt;     // Registers finished so far
    vl_t                   vl_r;
    vreg_idx_t             data_reg_r;
    vreg_idx_t             index_reg_r;
    logic                  busy_r;

    // Loop bookkeeping
    vl_t                   loop_end;     // Element count once this register is done
    vl_t                   remaining;    // Elements left for later registers
    logic                  last_loop;
    logic                  last_grant;
    logic                  new_loop;
    logic                  accept;
    logic                  advance;

    assign pending_ext = {2'b00, pending};
    assign ptr_nxt     = ptr + lane_idx_t'(1);

    assign loop_end  = (vl_t'(loop_cnt) + vl_t'(1)) << LANE_BITS;
    assign last_loop = (loop_end >= vl_r);
    assign remaining = vl_r - loop_end;     // Only read when not the last loop

    // ====================
    // Handshake strobes
    // ====================
    assign req_en_o   = pending_ext[ptr];
    assign advance    = req_en_o & grant_i;
    assign last_grant = advance & last_loop & ~pending_ext[ptr_nxt];  // Final element retires
    assign new_loop   = busy_r & ~|pending & ~last_loop;              // Gap cycle between regs

    assign ready_o  = ~busy_r | last_grant;   // Allows back-to-back acceptance
    assign busy_o   = busy_r;
    assign accept   = valid_i & ready_o;

    assign accept_o  = accept;
    assign advance_o = advance;

    // Unlock the data register once all its lanes are out
    assign unlock_en_o  = new_loop | last_grant;
    assign unlock_reg_o = data_reg_r;

    assign elem_ptr_o  = ptr;
    assign data_reg_o  = data_reg_r;
    assign index_reg_o = index_reg_r;

    // ====================
    // Element walk
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending     <= '0;
            ptr         <= '0;
            loop_cnt    <= '0;
            vl_r        <= '0;
            data_reg_r  <= '0;
            index_reg_r <= '0;
            busy_r      <= 1'b0;
        end else begin
            if (accept) begin
                pending     <= lane_mask(vl_i);    // First register
                ptr         <= '0;
                loop_cnt    <= '0;
                vl_r        <= vl_i;
                data_reg_r  <= data_reg_i;
                index_reg_r <= index_reg_i;
                busy_r      <= 1'b1;
            end else if (new_loop) begin
                pending     <= lane_mask(remaining);
                ptr         <= '0;
                loop_cnt    <= loop_cnt + vreg_idx_t'(1);
                data_reg_r  <= data_reg_r + vreg_idx_t'(1);   // Wraps modulo 32
                index_reg_r <= index_reg_r + vreg_idx_t'(1);
            end else if (advance) begin
                pending <= pending & ~(`VST_LANES'(1) << ptr);  // Clear retired lane
                ptr     <= ptr_nxt;
                if (last_grant) begin
                    busy_r <= 1'b0;
                end
            end
        end
    end

endmodule

/* verilog/vst_request_gen.sv */
// ====================
// Request address and data former
// ====================
`include "vst_defines.svh"

module vst_request_gen import vst_pkg::*; (
    input  logic       clk,
    input  mem_op_e    op_i,
    input  addr_t      base_i,
    input  addr_t      stride_i,
    input  logic       accept_i,      // Load instruction fields
    input  logic       advance_i,     // Step to the next element
    input  lane_idx_t  elem_ptr_i,
    input  vreg_data_t rd_data_1_i,   // Data register lanes
    input  vreg_data_t rd_data_2_i,   // Index register lanes
    output addr_t      req_addr_o,
    output elem_t      req_data_o
);

    localparam int LANE_BITS = $clog2(`VST_LANES);

    mem_op_e              op_r;
    addr_t                base_r;
    addr_t                stride_r;
    addr_t                run_addr;     // Address of the current element for non-indexed modes
    addr_t                step;
    logic [LANE_BITS-1:0] lane;
    logic                 lane_valid;   // Pointer is inside the register
    elem_t                data_lane;
    elem_t                offset_lane;

    // ====================
    // Instruction fields and running address
    // ====================
    always_ff @(posedge clk) begin
        if (accept_i) begin
            op_r     <= op_i;
            base_r   <= base_i;
            stride_r <= stride_i;
            run_addr <= base_i;          // Element 0
        end else if (advance_i) begin
            run_addr <= run_addr + step;
        end
    end

    // Unit stride moves by one element
    assign step = (op_r == OP_STRIDED) ? stride_r : addr_t'(`VST_DATA_W / 8);

    // ====================
    // Lane select
    // ====================
    assign lane       = elem_ptr_i[LANE_BITS-1:0];
    assign lane_valid = ~elem_ptr_i[LANE_BITS];
    assign data_lane   = rd_data_1_i[lane*`VST_DATA_W +: `VST_DATA_W];
    assign offset_lane = rd_data_2_i[lane*`VST_DATA_W +: `VST_DATA_W];

    // Zero data while the pointer sits past the last lane
    assign req_data_o = lane_valid ? data_lane : '0;

    always_comb begin
        case (op_r)
            OP_UNIT_STRIDED: req_addr_o = run_addr;
            OP_STRIDED:      req_addr_o = run_addr;
            OP_INDEXED:      req_addr_o = base_r + addr_t'(offset_lane);  // Offset in bytes
            default:         req_addr_o = run_addr;
        endcase
    end

endmodule

/* verilog/vst_range_track.sv */
// ====================
// Address range tracker
// First and last address of the accepted store
// ====================
`include "vst_defines.svh"

module vst_range_track import vst_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    accept_i,
    input  mem_op_e op_i,
    input  addr_t   base_i,
    input  addr_t   stride_i,
    input  vl_t     vl_i,
    output addr_t   start_addr_o,
    output addr_t   end_addr_o
);

    addr_t step;       // Byte distance between elements
    addr_t last_off;   // Offset of the last element
    vl_t   vl_m1;

    assign vl_m1 = vl_i - vl_t'(1);
    assign step  = (op_i == OP_STRIDED) ? stride_i : addr_t'(`VST_DATA_W / 8);
    assign last_off = addr_t'(vl_m1) * step;

    // ====================
    // Range registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_addr_o <= '0;
            end_addr_o   <= '1;     // Widest range until the first store
        end else if (accept_i) begin
            start_addr_o <= base_i;
            if (op_i == OP_INDEXED) begin
                end_addr_o <= base_i;              // Offsets unknown at accept time
            end else begin
                end_addr_o <= base_i + last_off;
            end
        end
    end

endmodule

/* verilog/vst_engine_top.sv */
// ====================
// Vector store engine top level
// Joins sequencing, request forming and range tracking
// ====================
`include "vst_defines.svh"

module vst_engine_top import vst_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // Instruction port
    input  logic       valid_i,
    input  mem_op_e    op_i,
    input  addr_t      base_i,
    input  addr_t      stride_i,
    input  vl_t        vl_i,            // At least 1
    input  vreg_idx_t  data_reg_i,
    input  vreg_idx_t  index_reg_i,
    output logic       ready_o,
    output logic       busy_o,
    // Register file read ports
    output vreg_idx_t  rd_addr_1_o,     // Data register
    input  vreg_data_t rd_data_1_i,
    output vreg_idx_t  rd_addr_2_o,     // Index register
    input  vreg_data_t rd_data_2_i,
    // Memory requests
    input  logic       grant_i,
    output logic       req_en_o,
    output addr_t      req_addr_o,
    output elem_t      req_data_o,
    // Register unlock
    output logic       unlock_en_o,
    output vreg_idx_t  unlock_reg_o,
    // Address range for load conflict checks
    output addr_t      start_addr_o,
    output addr_t      end_addr_o
);

    // ====================
    // Internal strobes
    // ====================
    logic      accept;      // Instruction taken this cycle
    logic      advance;     // Request retires this cycle
    lane_idx_t elem_ptr;    // Current lane within the register

    vst_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .vl_i        (vl_i),
        .data_reg_i  (data_reg_i),
        .index_reg_i (index_reg_i),
        .grant_i     (grant_i),
        .ready_o     (ready_o),
        .busy_o      (busy_o),
        .accept_o    (accept),
        .advance_o   (advance),
        .elem_ptr_o  (elem_ptr),
        .data_reg_o  (rd_addr_1_o),
        .index_reg_o (rd_addr_2_o),
        .req_en_o    (req_en_o),
        .unlock_en_o (unlock_en_o),
        .unlock_reg_o(unlock_reg_o)
    );

    vst_request_gen u_request_gen (
        .clk        (clk),
        .op_i       (op_i),
        .base_i     (base_i),
        .stride_i   (stride_i),
        .accept_i   (accept),
        .advance_i  (advance),
        .elem_ptr_i (elem_ptr),
        .rd_data_1_i(rd_data_1_i),
        .rd_data_2_i(rd_data_2_i),
        .req_addr_o (req_addr_o),
        .req_data_o (req_data_o)
    );

    vst_range_track u_range_track (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept_i    (accept),
        .op_i        (op_i),
        .base_i      (base_i),
        .stride_i    (stride_i),
        .vl_i        (vl_i),
        .start_addr_o(start_addr_o),
        .end_addr_o  (end_addr_o)
    );

endmodule

/* verification/vst_store_model.svh */
// ====================
// Vector store reference model
// Element placement, addresses, ranges and register contents
// ====================
`ifndef VST_STORE_MODEL_SVH
`define VST_STORE_MODEL_SVH

// Whole register file indexed by register then lane
typedef elem_t vrf_t [`VST_NUM_VREGS][`VST_LANES];

// Start-up word of one register lane that differs for every register and lane
function automatic elem_t reg_word(input int r, input int lane);
    return {8'(r), 8'(lane), 16'hc35a} ^ (32'(r * `VST_LANES + lane) * 32'h9e37_79b9);
endfunction

// Register that holds element k of a group starting at first
function automatic vreg_idx_t elem_reg(input vreg_idx_t first, input int k);
    return first + vreg_idx_t'(k / `VST_LANES);   // Wraps modulo 32
endfunction

function automatic int elem_lane(input int k);
    return k % `VST_LANES;
endfunction

// Lane value of element k as used for store data and for indexed offsets
function automatic elem_t elem_data(input vrf_t regs, input vreg_idx_t first, input int k);
    return regs[elem_reg(first, k)][elem_lane(k)];
endfunction

// Address of element k where the offset only matters for indexed stores
function automatic addr_t elem_addr(input mem_op_e o, input addr_t b, input addr_t s,
                                    input int k, input elem_t offset);
    case (o)
        OP_UNIT_STRIDED: return b + addr_t'(4 * k);
        OP_STRIDED:      return b + addr_t'(k) * s;
        default:         return b + offset;
    endcase
endfunction

// Last address reported for load conflict checks
function automatic addr_t range_end(input mem_op_e o, input addr_t b, input addr_t s,
                                    input vl_t n);
    if (o == OP_INDEXED) return b;                  // Real end unknown
    return elem_addr(o, b, s, int'(n) - 1, '0);
endfunction

`endif

/* verification/tb_vst_engine.sv */
// ====================
// Vector store engine testbench
// Random stores checked against a reference model
// ====================
`include "vst_defines.svh"

module tb_vst_engine import vst_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 37;
    localparam int TIMEOUT   = 300;     // Cycles allowed per wait

    logic       clk;
    logic       rst_n;
    logic       valid, grant;
    logic       ready, busy, req_en, unlock_en;
    mem_op_e    op;
    addr_t      base, stride, req_addr, start_addr, end_addr;
    vl_t        vl;
    vreg_idx_t  data_reg, index_reg, rd_addr_1, rd_addr_2, unlock_reg;
    vreg_data_t rd_data_1, rd_data_2;
    elem_t      req_data;

    `include "vst_store_model.svh"

    vrf_t        vrf;                   // Register file contents
    logic [31:0] rng;                   // xorshift state
    int          errors;
    int          failed;
    int          run;
    bit          hung;                  // Some wait ran out of cycles

    // Instruction slots where slot 1 is only used by back-to-back pairs
    mem_op_e    i_op [2];
    addr_t      i_base [2];
    addr_t      i_stride [2];
    vl_t        i_vl [2];
    vreg_idx_t  i_dreg [2];
    vreg_idx_t  i_ireg [2];

    vst_engine_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid),
        .op_i        (op),
        .base_i      (base),
        .stride_i    (stride),
        .vl_i        (vl),
        .data_reg_i  (data_reg),
        .index_reg_i (index_reg),
        .ready_o     (ready),
        .busy_o      (busy),
        .rd_addr_1_o (rd_addr_1),
        .rd_data_1_i (rd_data_1),
        .rd_addr_2_o (rd_addr_2),
        .rd_data_2_i (rd_data_2),
        .grant_i     (grant),
        .req_en_o    (req_en),
        .req_addr_o  (req_addr),
        .req_data_o  (req_data),
        .unlock_en_o (unlock_en),
        .unlock_reg_o(unlock_reg),
        .start_addr_o(start_addr),
        .end_addr_o  (end_addr)
    );

    // Register file answers combinationally with lane 0 in the low bits
    always_comb begin
        for (int l = 0; l < `VST_LANES; l++) begin
            rd_data_1[l*`VST_DATA_W +: `VST_DATA_W] = vrf[rd_addr_1][l];
            rd_data_2[l*`VST_DATA_W +: `VST_DATA_W] = vrf[rd_addr_2][l];
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic mismatch(input string name, input string what, input logic [31:0] exp,
                            input logic [31:0] act);
        $display("error %s: %s expected %h actual %h", name, what, exp, act);
        errors++;
    endtask

    task automatic fault(input string name, input string msg);
        $display("%s: %s", name, msg);
        errors++;
    endtask

    // Random instruction where indexed ones also get fresh offsets
    task automatic pick_instr(input int slot, input mem_op_e o);
        i_op[slot]     = o;
        i_base[slot]   = xorshift32() & 32'hffff_fffc;
        i_stride[slot] = xorshift32();
        i_vl[slot]     = vl_t'(xorshift32() % 32 + 1);
        i_dreg[slot]   = vreg_idx_t'(xorshift32());
        i_ireg[slot]   = vreg_idx_t'(xorshift32());
        if (o == OP_INDEXED) begin
            for (int r = 0; r <= (int'(i_vl[slot]) - 1) / `VST_LANES; r++) begin
                for (int l = 0; l < `VST_LANES; l++) begin
                    vrf[i_ireg[slot] + vreg_idx_t'(r)][l] = xorshift32() & 32'h0000_fffc;
                end
            end
        end
    endtask

    task automatic drive_instr(input int slot);
        valid     <= 1'b1;
        op        <= i_op[slot];
        base      <= i_base[slot];
        stride    <= i_stride[slot];
        vl        <= i_vl[slot];
        data_reg  <= i_dreg[slot];
        index_reg <= i_ireg[slot];
    endtask

    // Called at a falling edge and returns just after the acceptance edge
    task automatic wait_accept(input string name);
        int cycles;
        cycles = 0;
        while (ready !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ready !== 1'b1) begin
            fault(name, "instruction was never accepted");
            hung = 1'b1;
        end
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic check_reset(input string name);
        @(negedge clk);
        if (ready !== 1'b1) mismatch(name, "ready_o", 1, ready);
        if (busy !== 1'b0) mismatch(name, "busy_o", 0, busy);
        if (req_en !== 1'b0) mismatch(name, "req_en_o", 0, req_en);
        if (unlock_en !== 1'b0) mismatch(name, "unlock_en_o", 0, unlock_en);
        if (start_addr !== '0) mismatch(name, "start_addr_o", 0, start_addr);
        if (end_addr !== '1) mismatch(name, "end_addr_o", 32'hffff_ffff, end_addr);
    endtask

    // ====================
    // Store checker
    // ====================
    // Follows one store from the cycle after acceptance to its final grant
    task automatic run_store(input string name, input int slot, input bit rand_grant);
        int    k;                       // Elements retired
        int    unlocks;
        int    cycles;
        int    gap_k;                   // Element count at the last register gap
        bit    done;
        bit    held;                    // Request was refused last cycle
        addr_t held_addr;
        addr_t exp_addr;
        elem_t exp_data;
        k = 0;
        unlocks = 0;
        cycles = 0;
        gap_k = 0;
        done = 1'b0;
        held = 1'b0;
        held_addr = '0;
        @(negedge clk);
        exp_addr = range_end(i_op[slot], i_base[slot], i_stride[slot], i_vl[slot]);
        if (start_addr !== i_base[slot]) mismatch(name, "start_addr", i_base[slot], start_addr);
        if (end_addr !== exp_addr) mismatch(name, "end_addr", exp_addr, end_addr);
        while (!done && cycles < TIMEOUT) begin
            if (busy !== 1'b1) fault(name, "busy is low while the store is running");
            if (req_en) begin
                exp_addr = elem_addr(i_op[slot], i_base[slot], i_stride[slot], k,
                                     elem_data(vrf, i_ireg[slot], k));
                exp_data = elem_data(vrf, i_dreg[slot], k);
                if (held && req_addr !== held_addr) begin
                    fault(name, "request moved while grant was low");
                end
                if (k > 0 && k % `VST_LANES == 0 && gap_k != k) begin
                    fault(name, "no idle cycle between registers");
                end
                if (req_addr !== exp_addr) mismatch(name, "req_addr", exp_addr, req_addr);
                if (req_data !== exp_data) mismatch(name, "req_data", exp_data, req_data);
                held = !grant;
                held_addr = req_addr;
                if (grant) k++;
                done = grant && k == int'(i_vl[slot]);
                if (done) begin
                    unlocks++;
                    if (!unlock_en) fault(name, "no unlock on the final grant");
                    if (unlock_reg !== elem_reg(i_dreg[slot], k - 1)) begin
                        mismatch(name, "last unlock_reg", elem_reg(i_dreg[slot], k - 1),
                                 unlock_reg);
                    end
                    if (!ready) fault(name, "ready is low at the final grant");
                end else begin
                    if (unlock_en) fault(name, "unlock while the register still has requests");
                    if (ready) fault(name, "ready is high before the final grant");
                end
            end else begin
                held = 1'b0;
                if (!unlock_en || k == 0 || k % `VST_LANES != 0 || gap_k == k) begin
                    fault(name, "request enable low outside a register gap");
                end else begin
                    unlocks++;
                    gap_k = k;
                    if (unlock_reg !== elem_reg(i_dreg[slot], k - 1)) begin
                        mismatch(name, "unlock_reg", elem_reg(i_dreg[slot], k - 1), unlock_reg);
                    end
                end
            end
            if (!done) begin
                @(posedge clk);
                grant <= rand_grant ? (xorshift32() % 3) != 0 : 1'b1;   // About 2 in 3 granted
                @(negedge clk);
                cycles++;
            end
        end
        if (!done) begin
            fault(name, "timed out waiting for the final grant");
            hung = 1'b1;
        end else if (unlocks != (int'(i_vl[slot]) + 7) / 8) begin
            mismatch(name, "unlock count", (int'(i_vl[slot]) + 7) / 8, unlocks);
        end
    endtask

    task automatic single_store(input string name, input mem_op_e o, input bit rand_grant);
        pick_instr(0, o);
        @(posedge clk);
        grant <= 1'b1;
        drive_instr(0);
        @(negedge clk);
        wait_accept(name);
        if (!hung) run_store(name, 0, rand_grant);
    endtask

    // Second instruction waits on valid through the first one
    task automatic back_to_back(input string name);
        pick_instr(0, mem_op_e'(2'(xorshift32() % 3)));
        pick_instr(1, mem_op_e'(2'(xorshift32() % 3)));
        @(posedge clk);
        grant <= 1'b1;
        drive_instr(0);
        @(negedge clk);
        wait_accept(name);
        drive_instr(1);
        if (!hung) run_store(name, 0, 1'b0);
        if (!hung) begin
            if (!(valid && ready)) fault(name, "second instruction not taken at the final grant");
            wait_accept(name);
            run_store(name, 1, 1'b0);
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        string name;
        int    errs_before;
        valid     = 1'b0;
        grant     = 1'b0;
        op        = OP_UNIT_STRIDED;
        base      = '0;
        stride    = '0;
        vl        = vl_t'(1);
        data_reg  = '0;
        index_reg = '0;
        rst_n     = 1'b0;
        rng       = 32'h5cb5;
        errors    = 0;
        failed    = 0;
        run       = 0;
        hung      = 1'b0;
        for (int r = 0; r < `VST_NUM_VREGS; r++) begin
            for (int l = 0; l < `VST_LANES; l++) begin
                vrf[r][l] = reg_word(r, l);
            end
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS && !hung; t++) begin
            errs_before = errors;
            if (t == 0) begin
                name = "reset";
                check_reset(name);
            end else if (t <= 12 && t % 2 == 1) begin
                name = "unit_strided";
                single_store(name, OP_UNIT_STRIDED, 1'b0);
            end else if (t <= 12) begin
                name = "strided";
                single_store(name, OP_STRIDED, 1'b0);
            end else if (t <= 20) begin
                name = "indexed";
                single_store(name, OP_INDEXED, 1'b0);
            end else if (t <= 32) begin
                name = "backpressure";
                single_store(name, mem_op_e'(2'(xorshift32() % 3)), 1'b1);
            end else begin
                name = "back_to_back";
                back_to_back(name);
            end
            run++;
            if (errors == errs_before) begin
                $display("test %0d %s ok", t, name);
            end else begin
                failed++;
                $display("test %0d %s failed with %0d errors", t, name, errors - errs_before);
            end
        end
        $display("tests run %0d, failed %0d, errors %0d", run, failed, errors);
        if (errors == 0 && !hung) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+verilog
+incdir+verification
verilog/vst_pkg.sv
verilog/vst_sequencer.sv
verilog/vst_request_gen.sv
verilog/vst_range_track.sv
verilog/vst_engine_top.sv
verification/tb_vst_engine.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector store engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_vst_engine -f filelist.f -o vst_sim > build.log 2>&1 &&
./obj_dir/vst_sim > sim.log 2>&1 ||
{ cat build.log; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
